/* logic/fetch_pkg.sv */
// Shared definitions for the instruction fetch stage
// Widths, branch opcodes and vector typedefs
// Queue, training, lookup and decode bundles as packed structs
// Fetch control state encoding
package fetch_pkg;

	localparam int ADDR_W      = 32;
	localparam int INST_W      = 32;
	localparam int MMU_FLAGS_W = 12;
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int BTB_ENTRIES = 8;
	localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
	localparam int BTB_TAG_W   = ADDR_W - BTB_IDX_W - 2; // Bits 31 to 5

	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [INST_W-1:0]      inst_t;
	typedef logic [MMU_FLAGS_W-1:0] mmu_flags_t;
	typedef logic [31:0]            psr_t;
	typedef logic [9:0]             opcode_t;      // Instruction bits 30 to 21
	typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
	typedef logic [QUEUE_PTR_W:0]   queue_cnt_t;   // One extra bit to tell full from empty
	typedef logic [BTB_IDX_W-1:0]   btb_idx_t;
	typedef logic [BTB_TAG_W-1:0]   btb_tag_t;

	// Branch opcodes, all nonzero
	localparam opcode_t OC_B   = 10'h0B0;
	localparam opcode_t OC_BR  = 10'h0B1;
	localparam opcode_t OC_BUR = 10'h0B2;

	typedef struct packed {
		logic  kernel_access;
		logic  paging_ena;
		addr_t addr;
	} fetch_entry_t;

	// Resolved jump from decode
	typedef struct packed {
		logic  valid;
		logic  taken;
		addr_t target;
		addr_t inst_addr;
	} jump_result_t;

	typedef struct packed {
		logic  valid;
		addr_t addr;
	} predict_t;

	typedef struct packed {
		logic       valid;
		inst_t      inst;
		addr_t      pc;            // Address of the following instruction
		mmu_flags_t mmu_flags;
		logic       paging_ena;
		logic       kernel_access;
		logic       predict;
		addr_t      predict_addr;
	} next_out_t;

	typedef enum logic [1:0] {
		ST_RESET,
		ST_FETCH,
		ST_WAIT
	} fetch_state_t;

endpackage

/* logic/fetch_addr_queue.sv */
// Show-ahead synchronous FIFO of fetch entries
// Holds address and privilege flags of each request in flight
// Synchronous flush, full and empty flags
`timescale 1ns/1ps

module fetch_addr_queue (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    flush,
	input  logic                    push,
	input  fetch_pkg::fetch_entry_t push_entry,
	output logic                    full,
	input  logic                    pop,
	output fetch_pkg::fetch_entry_t head,
	output logic                    empty
);

	fetch_pkg::fetch_entry_t mem [fetch_pkg::QUEUE_DEPTH];
	fetch_pkg::queue_ptr_t   wr_ptr;
	fetch_pkg::queue_ptr_t   rd_ptr;
	fetch_pkg::queue_cnt_t   count;

	assign full  = (count == fetch_pkg::queue_cnt_t'(fetch_pkg::QUEUE_DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr]; // Head is visible without a read strobe

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Upstream gating must keep requests away from a full queue
	a_no_push_full: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(push && full && !flush));

	// Memory answers only requests that were queued
	a_no_pop_empty: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(pop && empty && !flush));

endmodule

/* logic/branch_predictor.sv */
// Direct-mapped branch target buffer
// Registered lookup for branches returned from memory
// Training write from resolved jumps in decode
`timescale 1ns/1ps

module branch_predictor (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    search,
	input  fetch_pkg::addr_t        search_addr,
	input  logic                    lock,
	output fetch_pkg::predict_t     result,
	input  fetch_pkg::jump_result_t jump
);

	fetch_pkg::btb_tag_t tag_mem    [fetch_pkg::BTB_ENTRIES];
	fetch_pkg::addr_t    target_mem [fetch_pkg::BTB_ENTRIES];
	logic [fetch_pkg::BTB_ENTRIES-1:0] entry_valid;

	fetch_pkg::btb_idx_t search_idx;
	fetch_pkg::btb_tag_t search_tag;
	fetch_pkg::btb_idx_t jump_idx;
	fetch_pkg::btb_tag_t jump_tag;
	logic                hit;

	// Tag is bits 31 to 5, index bits 4 to 2
	assign search_idx = search_addr[fetch_pkg::BTB_IDX_W+1:2];
	assign search_tag = search_addr[fetch_pkg::ADDR_W-1:fetch_pkg::BTB_IDX_W+2];
	assign jump_idx   = jump.inst_addr[fetch_pkg::BTB_IDX_W+1:2];
	assign jump_tag   = jump.inst_addr[fetch_pkg::ADDR_W-1:fetch_pkg::BTB_IDX_W+2];

	assign hit = entry_valid[search_idx] && (tag_mem[search_idx] == search_tag);

	// Tag and target arrays
	always_ff @(posedge iCLOCK) begin
		if (jump.valid) begin
			tag_mem[jump_idx]    <= jump_tag;
			target_mem[jump_idx] <= jump.target;
		end
	end

	// A not-taken result invalidates the entry
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
		end else if (jump.valid) begin
			entry_valid[jump_idx] <= jump.taken;
		end
	end

	// Lookup result lines up with the branch in the decode register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			result <= '0;
		end else if (!lock) begin
			result.valid <= search && hit;
			result.addr  <= target_mem[search_idx];
		end
	end

	// A lookup while decode holds would be dropped
	a_no_search_locked: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(search && lock));

endmodule

/* logic/fetch_control.sv */
// Fetch control
// Program counter state machine and request gating
// Branch detection, predicted redirect and flush
// Decode output register
`timescale 1ns/1ps

module fetch_control (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  fetch_pkg::psr_t         psr,
	input  logic                    exception_event,
	input  logic                    exception_addr_set,
	input  fetch_pkg::addr_t        exception_addr,
	output logic                    fetch_req,
	output fetch_pkg::addr_t        fetch_addr,
	output logic [1:0]              mmu_mode,
	output logic [2:0]              mmu_ps,
	input  logic                    fetch_lock,
	input  logic                    inst_valid,
	input  fetch_pkg::inst_t        inst,
	input  fetch_pkg::mmu_flags_t   mmu_flags,
	output logic                    inst_lock,
	output logic                    queue_push,
	output fetch_pkg::fetch_entry_t queue_entry,
	input  logic                    queue_full,
	output logic                    queue_flush,
	output logic                    queue_pop,
	input  fetch_pkg::fetch_entry_t queue_head,
	output logic                    search,
	output fetch_pkg::addr_t        search_addr,
	input  fetch_pkg::predict_t     predict,
	output logic                    predict_flush,
	output fetch_pkg::next_out_t    next_out,
	input  logic                    next_lock,
	input  logic                    next_fetch_stop
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::addr_t        pc;
	logic                    out_valid;
	fetch_pkg::inst_t        out_inst;
	fetch_pkg::addr_t        out_pc;
	fetch_pkg::mmu_flags_t   out_mmu_flags;
	logic                    out_paging_ena;
	logic                    out_kernel_access;

	function automatic logic is_branch(input fetch_pkg::inst_t word);
		fetch_pkg::opcode_t opcode;
		opcode = word[30:21];
		case (opcode)
			fetch_pkg::OC_B,
			fetch_pkg::OC_BR,
			fetch_pkg::OC_BUR: return 1'b1;
			default:           return 1'b0;
		endcase
	endfunction

	// Redirect only once decode takes the branch
	assign predict_flush = !next_lock && out_valid && predict.valid;

	assign fetch_req = (state == fetch_pkg::ST_FETCH) && !exception_event && !exception_addr_set
		&& !predict_flush && !queue_full && !fetch_lock && !next_fetch_stop;
	assign fetch_addr = pc;
	assign mmu_mode   = psr[1:0];
	assign mmu_ps     = psr[9:7];
	assign inst_lock  = next_lock;

	// Every accepted request leaves its entry in the queue
	assign queue_push                = fetch_req;
	assign queue_entry.kernel_access = !(psr[6] || psr[5]);
	assign queue_entry.paging_ena    = psr[1] || psr[0];
	assign queue_entry.addr          = pc;
	assign queue_flush               = exception_event || predict_flush;
	assign queue_pop                 = inst_valid;

	assign search      = inst_valid && !next_lock && is_branch(inst);
	assign search_addr = queue_head.addr;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pc    <= '0;
			state <= fetch_pkg::ST_RESET;
		end else if (exception_addr_set) begin
			pc    <= {exception_addr[fetch_pkg::ADDR_W-1:1], 1'b0}; // Halfword aligned restart
			state <= fetch_pkg::ST_FETCH;
		end else if (exception_event) begin
			state <= fetch_pkg::ST_WAIT;
		end else if (predict_flush) begin
			pc    <= predict.addr;
			state <= fetch_pkg::ST_FETCH;
		end else begin
			case (state)
				fetch_pkg::ST_RESET: begin
					pc    <= '0;
					state <= fetch_pkg::ST_FETCH;
				end
				fetch_pkg::ST_FETCH: begin
					if (fetch_req) begin
						pc <= pc + fetch_pkg::addr_t'(4);
					end
				end
				default: begin
					state <= fetch_pkg::ST_WAIT; // Hold until address-set
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
		end else if (exception_event || predict_flush) begin
			out_valid <= 1'b0;
		end else if (!next_lock) begin
			out_valid <= inst_valid;
		end
	end

	// Payload of the decode register
	always_ff @(posedge iCLOCK) begin
		if (!next_lock) begin
			out_inst          <= inst;
			out_mmu_flags     <= mmu_flags;
			out_paging_ena    <= queue_head.paging_ena;
			out_kernel_access <= queue_head.kernel_access;
			out_pc            <= queue_head.addr + fetch_pkg::addr_t'(4);
		end
	end

	assign next_out.valid         = out_valid;
	assign next_out.inst          = out_inst;
	assign next_out.pc            = out_pc;
	assign next_out.mmu_flags     = out_mmu_flags;
	assign next_out.paging_ena    = out_paging_ena;
	assign next_out.kernel_access = out_kernel_access;
	assign next_out.predict       = out_valid && predict.valid;
	assign next_out.predict_addr  = predict.addr;

	// Fetching stays stopped until the restart address arrives
	a_wait_addr_set: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		((exception_event || state == fetch_pkg::ST_WAIT) && !exception_addr_set)
		|=> !fetch_req);

endmodule

/* logic/fetch_unit.sv */
// Instruction fetch stage top level
// Address queue, branch target buffer and fetch control
`timescale 1ns/1ps

module fetch_unit (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  fetch_pkg::psr_t         psr,
	input  logic                    exception_event,
	input  logic                    exception_addr_set,
	input  fetch_pkg::addr_t        exception_addr,
	input  fetch_pkg::jump_result_t jump_result,
	output logic                    predict_flush,
	output logic                    fetch_req,
	output fetch_pkg::addr_t        fetch_addr,
	output logic [1:0]              mmu_mode,
	output logic [2:0]              mmu_ps,
	input  logic                    fetch_lock,
	input  logic                    inst_valid,
	input  fetch_pkg::inst_t        inst,
	input  fetch_pkg::mmu_flags_t   mmu_flags,
	output logic                    inst_lock,
	output fetch_pkg::next_out_t    next_out,
	input  logic                    next_lock,
	input  logic                    next_fetch_stop
);

	logic                    queue_push;
	logic                    queue_full;
	logic                    queue_flush;
	logic                    queue_pop;
	fetch_pkg::fetch_entry_t queue_entry;
	fetch_pkg::fetch_entry_t queue_head;
	logic                    search;
	fetch_pkg::addr_t        search_addr;
	fetch_pkg::predict_t     predict;

	fetch_addr_queue i_fetch_addr_queue (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.flush      (queue_flush),
		.push       (queue_push),
		.push_entry (queue_entry),
		.full       (queue_full),
		.pop        (queue_pop),
		.head       (queue_head),
		.empty      ()
	);

	branch_predictor i_branch_predictor (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.search      (search),
		.search_addr (search_addr),
		.lock        (next_lock),
		.result      (predict),
		.jump        (jump_result)
	);

	fetch_control i_fetch_control (
		.iCLOCK             (iCLOCK),
		.inRESET            (inRESET),
		.psr                (psr),
		.exception_event    (exception_event),
		.exception_addr_set (exception_addr_set),
		.exception_addr     (exception_addr),
		.fetch_req          (fetch_req),
		.fetch_addr         (fetch_addr),
		.mmu_mode           (mmu_mode),
		.mmu_ps             (mmu_ps),
		.fetch_lock         (fetch_lock),
		.inst_valid         (inst_valid),
		.inst               (inst),
		.mmu_flags          (mmu_flags),
		.inst_lock          (inst_lock),
		.queue_push         (queue_push),
		.queue_entry        (queue_entry),
		.queue_full         (queue_full),
		.queue_flush        (queue_flush),
		.queue_pop          (queue_pop),
		.queue_head         (queue_head),
		.search             (search),
		.search_addr        (search_addr),
		.predict            (predict),
		.predict_flush      (predict_flush),
		.next_out           (next_out),
		.next_lock          (next_lock),
		.next_fetch_stop    (next_fetch_stop)
	);

endmodule

/* sim/tb_clock_gen.sv */
// Testbench clock and reset generator
// 10 ns clock, reset held low for 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	initial begin
		inRESET = 1'b0;
		repeat (10) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1; // Release away from the active edge
	end

endmodule

/* sim/tb_fetch_unit.sv */
// Testbench for the instruction fetch stage
// Instruction memory model with random fetch_lock and fixed latency
// Decode model with random next_lock, commands read from a data file
// Value checks and watchdog
`timescale 1ns/1ps

module tb_fetch_unit;

	logic                    iCLOCK;
	logic                    inRESET;
	fetch_pkg::psr_t         psr                = '0;
	logic                    exception_event    = 1'b0;
	logic                    exception_addr_set = 1'b0;
	fetch_pkg::addr_t        exception_addr     = '0;
	fetch_pkg::jump_result_t jump_result        = '0;
	logic                    predict_flush;
	logic                    fetch_req;
	fetch_pkg::addr_t        fetch_addr;
	logic [1:0]              mmu_mode;
	logic [2:0]              mmu_ps;
	logic                    fetch_lock         = 1'b0;
	logic                    inst_valid         = 1'b0;
	fetch_pkg::inst_t        inst               = '0;
	fetch_pkg::mmu_flags_t   mmu_flags          = '0;
	logic                    inst_lock;
	fetch_pkg::next_out_t    next_out;
	logic                    next_lock          = 1'b1;
	logic                    next_fetch_stop    = 1'b0;

	int          seed      = 79;
	int          cycle     = 0;
	int          x_count   = 0;
	logic        loaded    = 1'b0;
	logic        lock_next = 1'b1; // Decode lock for the coming cycle
	logic [31:0] mem_word [logic [31:0]];
	logic [31:0] pend_addr [$];
	int          pend_ready [$];
	string       lines [$];

	tb_clock_gen i_tb_clock_gen (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET)
	);

	fetch_unit i_fetch_unit (
		.iCLOCK             (iCLOCK),
		.inRESET            (inRESET),
		.psr                (psr),
		.exception_event    (exception_event),
		.exception_addr_set (exception_addr_set),
		.exception_addr     (exception_addr),
		.jump_result        (jump_result),
		.predict_flush      (predict_flush),
		.fetch_req          (fetch_req),
		.fetch_addr         (fetch_addr),
		.mmu_mode           (mmu_mode),
		.mmu_ps             (mmu_ps),
		.fetch_lock         (fetch_lock),
		.inst_valid         (inst_valid),
		.inst               (inst),
		.mmu_flags          (mmu_flags),
		.inst_lock          (inst_lock),
		.next_out           (next_out),
		.next_lock          (next_lock),
		.next_fetch_stop    (next_fetch_stop)
	);

	// Default word is the address itself
	function automatic logic [31:0] memory_word(input logic [31:0] addr);
		if (mem_word.exists(addr)) begin
			return mem_word[addr];
		end
		return addr;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h", name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Memory side, sampled in mid cycle
	always @(negedge iCLOCK) begin
		check_value("inst_lock", 32'(inst_lock), 32'(next_lock));
		if (inst_valid) begin
			void'(pend_addr.pop_front());
			void'(pend_ready.pop_front());
		end
		if (predict_flush || exception_event) begin
			pend_addr.delete(); // Drop everything in flight
			pend_ready.delete();
		end
		if (inRESET && fetch_req) begin
			pend_addr.push_back(fetch_addr);
			pend_ready.push_back(cycle + 2);
		end
	end

	// Memory and decode drive
	always @(posedge iCLOCK) begin
		cycle = cycle + 1;
		fetch_lock      <= (($random(seed) & 3) == 0);
		next_fetch_stop <= (($random(seed) & 7) == 0);
		next_lock       <= lock_next;
		if (!lock_next && pend_addr.size() > 0 && pend_ready[0] <= cycle) begin
			inst_valid <= 1'b1; // Never while inst_lock is high
			inst       <= memory_word(pend_addr[0]);
			mmu_flags  <= pend_addr[0][13:2];
		end else begin
			inst_valid <= 1'b0;
		end
	end

	task automatic apply_status(input logic [31:0] value);
		@(posedge iCLOCK);
		psr <= value;
		@(negedge iCLOCK);
		check_value("mmu_mode", 32'(mmu_mode), 32'(value[1:0]));
		check_value("mmu_ps", 32'(mmu_ps), 32'(value[9:7]));
	endtask

	task automatic train_predictor(input logic [31:0] inst_addr, input logic [31:0] target,
		input logic taken);
		fetch_pkg::jump_result_t jr;
		jr.valid     = 1'b1;
		jr.taken     = taken;
		jr.target    = target;
		jr.inst_addr = inst_addr;
		@(posedge iCLOCK);
		jump_result <= jr;
		@(posedge iCLOCK);
		jump_result <= '0;
	endtask

	task automatic raise_exception(input logic [31:0] addr);
		@(posedge iCLOCK);
		exception_event <= 1'b1;
		@(posedge iCLOCK);
		exception_event <= 1'b0;
		repeat (3) @(posedge iCLOCK);
		exception_addr_set <= 1'b1;
		exception_addr     <= addr;
		@(posedge iCLOCK);
		exception_addr_set <= 1'b0;
	endtask

	// Waits for decode to take the next valid output
	task automatic expect_output(input logic [31:0] pc, input logic [31:0] word,
		input logic paging, input logic kernel, input logic predict, input logic [31:0] target);
		logic        taken;
		logic [31:0] addr;
		taken = 1'b0;
		addr  = pc - 32'd4; // Address of the instruction itself
		while (!taken) begin
			@(negedge iCLOCK);
			if (next_out.valid && !next_lock) begin
				check_value("next_out.pc", next_out.pc, pc);
				check_value("next_out.inst", next_out.inst, word);
				check_value("next_out.mmu_flags", 32'(next_out.mmu_flags), 32'(addr[13:2]));
				check_value("next_out.paging_ena", 32'(next_out.paging_ena), 32'(paging));
				check_value("next_out.kernel_access", 32'(next_out.kernel_access),
					32'(kernel));
				check_value("next_out.predict", 32'(next_out.predict), 32'(predict));
				if (predict) begin
					check_value("next_out.predict_addr", next_out.predict_addr, target);
				end
				taken     = 1'b1;
				lock_next = 1'b1; // Stall until the next expected output
			end else begin
				lock_next = (($random(seed) & 3) == 0);
			end
		end
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		string       args;
		byte         cmd;
		logic [31:0] v0, v1, v2, v3, v4, v5;
		fd = $fopen("sim/fetch_input.txt", "r");
		if (fd == 0) begin
			$display("Error: the stimulus file sim/fetch_input.txt could not be opened");
			$display("SIMULATION FAILED");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				lines.push_back(line);
				if (line.getc(0) == "X") begin
					x_count = x_count + 1;
				end
			end
		end
		$fclose(fd);
		loaded = 1'b1;
		@(posedge inRESET);
		@(posedge iCLOCK);
		foreach (lines[i]) begin
			cmd  = lines[i].getc(0);
			args = lines[i].substr(1, lines[i].len() - 1);
			n    = $sscanf(args, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
			case (cmd)
				"M": mem_word[v0] = v1;
				"P": apply_status(v0);
				"T": train_predictor(v0, v1, v2[0]);
				"E": raise_exception(v0);
				"X": expect_output(v0, v1, v2[0], v3[0], v4[0], v5);
				default: begin
					$display("Error: unknown command in stimulus line %0d", i);
					$display("SIMULATION FAILED");
					$fatal(1);
				end
			endcase
		end
		@(posedge iCLOCK);
		$display("SIMULATION PASSED");
		$finish;
	end

	// Budget grows with the number of expected outputs
	initial begin
		wait (loaded);
		repeat (x_count * 200 + lines.size() * 20 + 100) @(posedge iCLOCK);
		$display("Error: timeout, decode outputs stopped arriving");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

endmodule

/* sim/fetch_input.txt */
# M addr word | P psr | T inst_addr target taken | E restart_addr
# X pc inst paging_ena kernel_access predict predict_addr (all hex)
# Branch words: B 16000000, BR 16200000, BUR 16400000
M 00000010 16000000
M 00000050 16200000
M 00000058 16400000
M 00000208 16000000
T 00000010 00000040 1
T 00000058 00000080 1
T 00000058 00000080 0
T 00000208 00000300 1
X 00000004 00000000 0 1 0 0
X 00000008 00000004 0 1 0 0
X 0000000c 00000008 0 1 0 0
X 00000010 0000000c 0 1 0 0
X 00000014 16000000 0 1 1 00000040
X 00000044 00000040 0 1 0 0
X 00000048 00000044 0 1 0 0
X 0000004c 00000048 0 1 0 0
X 00000050 0000004c 0 1 0 0
X 00000054 16200000 0 1 0 0
X 00000058 00000054 0 1 0 0
X 0000005c 16400000 0 1 0 0
X 00000060 0000005c 0 1 0 0
P 000002a1
E 00000101
X 00000104 00000100 1 0 0 0
X 00000108 00000104 1 0 0 0
X 0000010c 00000108 1 0 0 0
P 00000003
E 00000201
X 00000204 00000200 1 1 0 0
X 00000208 00000204 1 1 0 0
X 0000020c 16000000 1 1 1 00000300
X 00000304 00000300 1 1 0 0
X 00000308 00000304 1 1 0 0

/* filelist.f */
logic/fetch_pkg.sv
logic/fetch_addr_queue.sv
logic/branch_predictor.sv
logic/fetch_control.sv
logic/fetch_unit.sv
sim/tb_clock_gen.sv
sim/tb_fetch_unit.sv

/* Makefile */
SRCS := $(wildcard logic/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_fetch_unit: $(SRCS) filelist.f
	verilator --binary --timing --assert --top-module tb_fetch_unit \
		-f filelist.f -o Vtb_fetch_unit

run: obj_dir/Vtb_fetch_unit
	./obj_dir/Vtb_fetch_unit | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
